/* ddram.f */
+incdir+hw
hw/ddram_pkg.sv
hw/ddram_csr.sv
hw/ddram_ctrl.sv
hw/ddram_datapath.sv
hw/ddram.sv
test/ddram_props.sv
test/ddram_checker.sv
test/ddram_tb.sv

/* hw/ddram.sv */
// ddram top level
// single-rank sdram controller: the csr block steers the command
// controller and the datapath, which together serve 64-bit fml requests
// on a 32-bit sdram. the pad clock is sys_clk

`timescale 1ns/1ps
`include "ddram_defs.svh"

module ddram #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic                           sys_clk,
	input  logic                           arst_n,
	// configuration bus
	input  logic [`DDRAM_CSR_AW-1:0]       csr_a,
	input  logic                           csr_we,
	input  logic [31:0]                    csr_di,
	output logic [31:0]                    csr_do,
	// fml memory bus
	input  logic [`DDRAM_DEPTH-1:0]        fml_adr,
	input  logic                           fml_stb,
	input  logic                           fml_we,
	output logic                           fml_ack,
	input  logic [7:0]                     fml_sel,
	input  logic [63:0]                    fml_di,
	output logic [63:0]                    fml_do,
	// sdram pads
	output logic                           sdram_cke,
	output logic                           sdram_cs_n,
	output logic                           sdram_we_n,
	output logic                           sdram_cas_n,
	output logic                           sdram_ras_n,
	output logic [`DDRAM_ROWDEPTH-1:0]     sdram_adr,
	output logic [`DDRAM_BANKDEPTH-1:0]    sdram_ba,
	output logic [3:0]                     sdram_dm,
	inout  wire  [31:0]                    sdram_dq
);

	import ddram_pkg::*;

	logic                        bypass;
	logic                        sdram_rst;
	logic                        cke;
	logic [2:0]                  t_rp;
	logic [2:0]                  t_rcd;
	logic [3:0]                  t_rfc;
	logic [10:0]                 t_refi;
	logic                        byp_valid; // bypass command pulse
	cmd_t                        byp_cmd;
	logic                        byp_cs;
	logic [`DDRAM_ROWDEPTH-1:0]  byp_adr;
	logic [`DDRAM_BANKDEPTH-1:0] byp_ba;
	logic                        wr_start;  // wr issued, beats follow
	logic                        rd_start;  // rd issued, capture follows
	logic                        rd_done;   // both read beats captured

	ddram_csr #(.csr_addr(csr_addr)) csr (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.bypass(bypass), .sdram_rst(sdram_rst), .cke(cke),
		.t_rp(t_rp), .t_rcd(t_rcd), .t_rfc(t_rfc), .t_refi(t_refi),
		.byp_valid(byp_valid), .byp_cmd(byp_cmd), .byp_cs(byp_cs),
		.byp_adr(byp_adr), .byp_ba(byp_ba)
	);

	ddram_ctrl ctrl (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.bypass(bypass), .sdram_rst(sdram_rst), .cke(cke),
		.t_rp(t_rp), .t_rcd(t_rcd), .t_rfc(t_rfc), .t_refi(t_refi),
		.byp_valid(byp_valid), .byp_cmd(byp_cmd), .byp_cs(byp_cs),
		.byp_adr(byp_adr), .byp_ba(byp_ba),
		.fml_adr(fml_adr), .fml_stb(fml_stb), .fml_we(fml_we), .fml_ack(fml_ack),
		.rd_done(rd_done), .wr_start(wr_start), .rd_start(rd_start),
		.sdram_cke(sdram_cke), .sdram_cs_n(sdram_cs_n),
		.sdram_ras_n(sdram_ras_n), .sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n),
		.sdram_adr(sdram_adr), .sdram_ba(sdram_ba)
	);

	ddram_datapath datapath (
		.sys_clk(sys_clk), .arst_n(arst_n),
		.wr_start(wr_start), .rd_start(rd_start),
		.fml_di(fml_di), .fml_sel(fml_sel), .fml_do(fml_do), .rd_done(rd_done),
		.sdram_dq(sdram_dq), .sdram_dm(sdram_dm)
	);

endmodule

/* hw/ddram_csr.sv */
// ddram configuration registers
// decodes the csr block select, holds the control bits and the sdram
// timing values, returns a registered read-back and turns a write to
// the bypass command register into a one-cycle command pulse

`timescale 1ns/1ps
`include "ddram_defs.svh"

module ddram_csr #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic                           sys_clk,
	input  logic                           arst_n,
	input  logic [`DDRAM_CSR_AW-1:0]       csr_a,
	input  logic                           csr_we,
	input  logic [31:0]                    csr_di,
	output logic [31:0]                    csr_do,
	output logic                           bypass,
	output logic                           sdram_rst,
	output logic                           cke,
	output logic [2:0]                     t_rp,
	output logic [2:0]                     t_rcd,
	output logic [3:0]                     t_rfc,
	output logic [10:0]                    t_refi,
	output logic                           byp_valid,
	output ddram_pkg::cmd_t                byp_cmd,
	output logic                           byp_cs,
	output logic [`DDRAM_ROWDEPTH-1:0]     byp_adr,
	output logic [`DDRAM_BANKDEPTH-1:0]    byp_ba
);

	import ddram_pkg::*;

	logic sel; // this block is addressed
	logic wr;  // write strobe for this block

	assign sel = (csr_a[`DDRAM_CSR_AW-1:`DDRAM_CSR_SEL_LSB] == csr_addr);
	assign wr  = sel & csr_we;

	// control and timing registers, reset leaves the sdram in bypass and reset
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			bypass    <= 1'b1;
			sdram_rst <= 1'b1;
			cke       <= 1'b0;
			t_rp      <= 3'd2;
			t_rcd     <= 3'd2;
			t_rfc     <= 4'd8;
			t_refi    <= 11'd780;
		end else if (wr) begin
			case (csr_a[1:0])
				2'd0: begin
					bypass    <= csr_di[0];
					sdram_rst <= csr_di[1];
					cke       <= csr_di[2];
				end
				2'd2: begin
					t_rp   <= csr_di[2:0];
					t_rcd  <= csr_di[5:3];
					t_rfc  <= csr_di[9:6];
					t_refi <= csr_di[20:10];
				end
				default: ; // index 1 is the bypass pulse, index 3 is unused
			endcase
		end
	end

	// the bypass command goes straight to the controller, which registers it
	// onto the pads, so it shows in the cycle right after the write edge
	assign byp_valid = wr & (csr_a[1:0] == 2'd1);
	assign byp_cs    = csr_di[0];
	assign byp_cmd   = cmd_t'({~csr_di[3], ~csr_di[2], ~csr_di[1]}); // active high bits to pads
	assign byp_adr   = csr_di[16:4];
	assign byp_ba    = csr_di[18:17];

	// read-back lags the address by one cycle, zero when not selected
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (sel) begin
				case (csr_a[1:0])
					2'd0:    csr_do <= {29'd0, cke, sdram_rst, bypass};
					2'd2:    csr_do <= {11'd0, t_refi, t_rfc, t_rcd, t_rp};
					default: csr_do <= '0; // bypass command register is write only
				endcase
			end
		end
	end

endmodule

/* hw/ddram_ctrl.sv */
// ddram command controller
// serves each fml request as a closed-page access (act, rd or wr, pre),
// issues auto refresh on the programmed interval and generates the fml
// acknowledge. in bypass mode the csr command pulse drives the pads

`timescale 1ns/1ps
`include "ddram_defs.svh"

module ddram_ctrl (
	input  logic                           sys_clk,
	input  logic                           arst_n,
	input  logic                           bypass,
	input  logic                           sdram_rst,
	input  logic                           cke,
	input  logic [2:0]                     t_rp,
	input  logic [2:0]                     t_rcd,
	input  logic [3:0]                     t_rfc,
	input  logic [10:0]                    t_refi,
	input  logic                           byp_valid,
	input  ddram_pkg::cmd_t                byp_cmd,
	input  logic                           byp_cs,
	input  logic [`DDRAM_ROWDEPTH-1:0]     byp_adr,
	input  logic [`DDRAM_BANKDEPTH-1:0]    byp_ba,
	input  logic [`DDRAM_DEPTH-1:0]        fml_adr,
	input  logic                           fml_stb,
	input  logic                           fml_we,
	output logic                           fml_ack,
	input  logic                           rd_done,
	output logic                           wr_start,
	output logic                           rd_start,
	output logic                           sdram_cke,
	output logic                           sdram_cs_n,
	output logic                           sdram_ras_n,
	output logic                           sdram_cas_n,
	output logic                           sdram_we_n,
	output logic [`DDRAM_ROWDEPTH-1:0]     sdram_adr,
	output logic [`DDRAM_BANKDEPTH-1:0]    sdram_ba
);

	import ddram_pkg::*;

	ctrl_state_t                    state;
	cmd_t                           cmd_q;       // registered pad command
	logic [3:0]                     cnt;         // shared wait counter
	logic [10:0]                    refi_cnt;    // refresh interval countdown
	logic                           ref_pending; // interval expired, refresh owed
	logic                           ref_seq;     // current pre belongs to a refresh
	logic                           ack_q;       // write acknowledge, comes with pre
	logic                           run;         // normal operation allowed
	logic                           ref_start;
	logic [`DDRAM_ROWDEPTH-1:0]     adr_row;
	logic [`DDRAM_ROWDEPTH-1:0]     adr_col;
	logic [`DDRAM_BANKDEPTH-1:0]    bank;

	assign run       = ~bypass & ~sdram_rst;
	assign ref_start = (state == IDLE) & run & ref_pending; // refresh wins over a request

	// address split, the column gets a zero beat bit at the bottom
	assign adr_row = `DDRAM_ROWDEPTH'(fml_adr[`DDRAM_ROW_MSB:`DDRAM_ROW_LSB]);
	assign adr_col = `DDRAM_ROWDEPTH'({fml_adr[`DDRAM_COL_MSB:`DDRAM_COL_LSB], 1'b0});
	assign bank    = fml_adr[`DDRAM_BANK_MSB:`DDRAM_BANK_LSB];

	assign {sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;
	assign fml_ack = ack_q | rd_done; // read ack follows the datapath capture

	// refresh interval timer, held at the reload value in bypass
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			refi_cnt    <= '0;
			ref_pending <= 1'b0;
		end else begin
			if (ref_start)
				ref_pending <= 1'b0;
			if (bypass) begin
				refi_cnt <= t_refi;
			end else if (refi_cnt == '0) begin
				refi_cnt    <= t_refi;
				ref_pending <= 1'b1; // a new expiry beats a clear in the same cycle
			end else begin
				refi_cnt <= refi_cnt - 11'd1;
			end
		end
	end

	// access sequencer; every state that issues a command sets it on the
	// pads as the state is entered, wait states last max(cnt, 1) cycles
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= IDLE;
			cnt        <= '0;
			ref_seq    <= 1'b0;
			ack_q      <= 1'b0;
			wr_start   <= 1'b0;
			rd_start   <= 1'b0;
			cmd_q      <= NOP;
			sdram_cke  <= 1'b0;
			sdram_cs_n <= 1'b1;
			sdram_adr  <= '0;
			sdram_ba   <= '0;
		end else begin
			cmd_q      <= NOP; // nop unless a state below issues a command
			sdram_cs_n <= 1'b0;
			sdram_cke  <= cke;
			ack_q      <= 1'b0;
			wr_start   <= 1'b0;
			rd_start   <= 1'b0;
			case (state)
				IDLE: begin
					if (ref_start) begin
						state     <= PRECHARGE;
						cmd_q     <= PRE;
						sdram_adr <= `DDRAM_ROWDEPTH'(1) << `DDRAM_A10; // all banks
						ref_seq   <= 1'b1;
					end else if (run && fml_stb) begin
						state     <= ACTIVATE;
						cmd_q     <= ACT;
						sdram_adr <= adr_row;
						sdram_ba  <= bank;
					end
				end
				ACTIVATE: begin
					state <= RCD_WAIT;
					cnt   <= {1'b0, t_rcd};
				end
				RCD_WAIT: begin
					if (cnt <= 4'd1) begin
						state     <= ACCESS;
						cmd_q     <= fml_we ? WR : RD;
						sdram_adr <= adr_col; // a10 low, no auto precharge
						sdram_ba  <= bank;
						wr_start  <= fml_we;
						rd_start  <= ~fml_we;
					end else begin
						cnt <= cnt - 4'd1;
					end
				end
				ACCESS: begin
					state <= DATA_WAIT;
					cnt   <= fml_we ? 4'd2 : 4'(`DDRAM_CL + 1); // two beats or latency
				end
				DATA_WAIT: begin
					if (cnt <= 4'd1) begin
						state     <= PRECHARGE;
						cmd_q     <= PRE;
						sdram_adr <= '0; // single bank close
						sdram_ba  <= bank;
						ack_q     <= fml_we;
					end else begin
						cnt <= cnt - 4'd1;
					end
				end
				PRECHARGE: begin
					state <= RP_WAIT;
					cnt   <= {1'b0, t_rp};
				end
				RP_WAIT: begin
					if (cnt <= 4'd1) begin
						if (ref_seq) begin
							state   <= REFRESH;
							cmd_q   <= REF;
							ref_seq <= 1'b0;
						end else begin
							state <= IDLE;
						end
					end else begin
						cnt <= cnt - 4'd1;
					end
				end
				REFRESH: begin
					state <= RFC_WAIT;
					cnt   <= t_rfc;
				end
				RFC_WAIT: begin
					if (cnt <= 4'd1)
						state <= IDLE;
					else
						cnt <= cnt - 4'd1;
				end
				default: state <= IDLE;
			endcase
			// software owns the pads in bypass, one command per csr write
			if (bypass) begin
				sdram_cs_n <= ~(byp_valid & byp_cs);
				cmd_q      <= byp_valid ? byp_cmd : NOP;
				if (byp_valid) begin
					sdram_adr <= byp_adr;
					sdram_ba  <= byp_ba;
				end
			end
		end
	end

endmodule

/* hw/ddram_datapath.sv */
// ddram datapath
// splits a 64-bit fml word into two 32-bit beats with byte masks, drives
// the dq pads only during write beats and assembles the two read beats
// captured at the fixed cas latency into fml_do

`timescale 1ns/1ps
`include "ddram_defs.svh"

module ddram_datapath (
	input  logic        sys_clk,
	input  logic        arst_n,
	input  logic        wr_start,
	input  logic        rd_start,
	input  logic [63:0] fml_di,
	input  logic [7:0]  fml_sel,
	output logic [63:0] fml_do,
	output logic        rd_done,
	inout  wire  [31:0] sdram_dq,
	output logic [3:0]  sdram_dm
);

	logic                wr_q;    // second write beat is next
	logic                dq_oe;   // pad drivers enabled
	logic [31:0]         dq_out;  // beat on the pads
	logic [`DDRAM_CL+1:0] rd_pipe; // one bit per cycle since each rd

	// write beats, upper half first, mask is the inverse of the byte selects
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_q     <= 1'b0;
			dq_oe    <= 1'b0;
			sdram_dm <= 4'h0;
		end else begin
			wr_q  <= wr_start;
			dq_oe <= wr_start | wr_q; // high for the two cycles after wr
			if (wr_start)
				sdram_dm <= ~fml_sel[7:4];
			else if (wr_q)
				sdram_dm <= ~fml_sel[3:0];
			else
				sdram_dm <= 4'h0; // keep reads unmasked
		end
	end

	always_ff @(posedge sys_clk) begin
		dq_out <= wr_start ? fml_di[63:32] : fml_di[31:0];
	end

	assign sdram_dq = dq_oe ? dq_out : 'z;

	// read latency pipeline, each rd travels on its own so a new one can
	// be in flight while an older capture completes
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[`DDRAM_CL:0], rd_start};
	end

	assign rd_done = rd_pipe[`DDRAM_CL+1]; // fml_do holds both beats here

	// beat 0 is on dq cl cycles after rd, beat 1 the cycle after
	always_ff @(posedge sys_clk) begin
		if (rd_pipe[`DDRAM_CL-1])
			fml_do[63:32] <= sdram_dq;
		if (rd_pipe[`DDRAM_CL])
			fml_do[31:0] <= sdram_dq;
	end

endmodule

/* hw/ddram_defs.svh */
// ddram shared constants
// address widths, the split of a 64-bit fml word address into sdram
// column, bank and row fields, the cas latency and the csr block select
`ifndef DDRAM_DEFS_SVH
`define DDRAM_DEFS_SVH

`define DDRAM_DEPTH     25 // fml byte address width
`define DDRAM_COLDEPTH  9  // column address width in 32-bit words
`define DDRAM_ROWDEPTH  13 // row address width, also the pad address width
`define DDRAM_BANKDEPTH 2  // bank address width
`define DDRAM_CL        2  // cas latency in sys_clk cycles
`define DDRAM_CSR_AW    14 // csr address width

// fml_adr field positions, the low 3 bits select a byte inside the 64-bit word
`define DDRAM_COL_LSB   3                                          // lowest word index bit
`define DDRAM_COL_MSB   (`DDRAM_COL_LSB + `DDRAM_COLDEPTH - 2)     // column minus the beat bit
`define DDRAM_BANK_LSB  (`DDRAM_COL_MSB + 1)
`define DDRAM_BANK_MSB  (`DDRAM_BANK_LSB + `DDRAM_BANKDEPTH - 1)
`define DDRAM_ROW_LSB   (`DDRAM_BANK_MSB + 1)
`define DDRAM_ROW_MSB   (`DDRAM_DEPTH - 1)                         // rows above the banks
`define DDRAM_A10       10                                         // all-bank precharge bit

// the top 4 csr address bits select this block
`define DDRAM_CSR_SEL_LSB (`DDRAM_CSR_AW - 4)

`endif

/* hw/ddram_pkg.sv */
// ddram types
// sdram command encoding and the command controller states

package ddram_pkg;

	// value is the {ras_n, cas_n, we_n} pad encoding, cs_n is driven apart
	typedef enum logic [2:0] {
		MRS = 3'b000, // load mode register
		REF = 3'b001, // auto refresh
		PRE = 3'b010, // precharge, a10 selects all banks
		ACT = 3'b011, // open a row
		WR  = 3'b100, // write, column on the address pads
		RD  = 3'b101, // read, column on the address pads
		NOP = 3'b111  // no operation
	} cmd_t;

	typedef enum logic [3:0] {
		IDLE,      // waiting for a request or a pending refresh
		ACTIVATE,  // act is on the pads
		RCD_WAIT,  // row to column delay
		ACCESS,    // rd or wr is on the pads
		DATA_WAIT, // data beats and read latency
		PRECHARGE, // pre is on the pads
		RP_WAIT,   // precharge recovery
		REFRESH,   // ref is on the pads
		RFC_WAIT   // refresh cycle time
	} ctrl_state_t;

endpackage

/* test/ddram_checker.sv */
// ddram checker
// watches the csr and fml ports, keeps a byte-masked reference memory
// of 64-bit words filled from acked writes and compares read data

`timescale 1ns/1ps
`include "ddram_defs.svh"

module ddram_checker (
	input logic                     sys_clk,
	input logic                     arst_n,
	input logic [`DDRAM_CSR_AW-1:0] csr_a,
	input logic                     csr_we,
	input logic [31:0]              csr_di,
	input logic [`DDRAM_DEPTH-1:0]  fml_adr,
	input logic                     fml_we,
	input logic                     fml_ack,
	input logic [7:0]               fml_sel,
	input logic [63:0]              fml_di,
	input logic [63:0]              fml_do
);

	logic [63:0] ref_mem [logic [21:0]]; // reference words by word address
	logic [7:0]  ref_vld [logic [21:0]]; // bytes that were ever written
	int          checks = 0;
	int          errors = 0;
	int          test_errs = 0; // error count when the current test began
	logic        byp_q = 1'b1;  // bypass bit as last written over csr

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		checks++;
		errors++;
		$display("%0t: %s", $time, msg); // plain words for non-value failures
	endtask

	task automatic test_done(input string name);
		$display("test %s: %s, %0d errors", name,
			(errors == test_errs) ? "passed" : "failed", errors - test_errs);
		test_errs = errors;
	endtask

	task automatic summary(input int assert_fails);
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			assert_fails);
	endtask

	// sampled on the rising edge, so every value seen is the settled one
	always @(posedge sys_clk) begin
		logic [21:0] w;
		logic [63:0] m;
		w = fml_adr[`DDRAM_DEPTH-1:3];
		if (arst_n && fml_ack) begin
			if (byp_q)
				note_failure("fml request acknowledged while bypass is set");
			if (fml_we) begin
				if (!ref_mem.exists(w)) begin
					ref_mem[w] = '0;
					ref_vld[w] = '0;
				end
				for (int i = 0; i < 8; i++)
					if (fml_sel[i]) begin
						ref_mem[w][8*i +: 8] = fml_di[8*i +: 8];
						ref_vld[w][i] = 1'b1;
					end
			end else if (ref_mem.exists(w)) begin
				m = '0;
				for (int i = 0; i < 8; i++)
					m[8*i +: 8] = {8{ref_vld[w][i]}}; // unwritten bytes are ignored
				check_value("read data", fml_do & m, ref_mem[w] & m);
			end
		end
		if (csr_we && csr_a[`DDRAM_CSR_AW-1:`DDRAM_CSR_SEL_LSB] == 4'h0 && csr_a[1:0] == 2'd0)
			byp_q = csr_di[0];
	end

endmodule

/* test/ddram_props.sv */
// ddram controller timing properties
// bound into the command controller, checks act, pre and ref spacing
// against the programmed timings and the one-cycle fml acknowledge

`timescale 1ns/1ps

module ddram_props (
	input logic            sys_clk,
	input logic            arst_n,
	input logic            bypass,
	input logic [2:0]      t_rp,
	input logic [2:0]      t_rcd,
	input logic [3:0]      t_rfc,
	input logic            fml_ack,
	input ddram_pkg::cmd_t cmd_q
);

	import ddram_pkg::*;

	logic [7:0] since_act; // cycles since the last act on the pads
	logic [7:0] since_pre;
	logic [7:0] since_ref;
	int         fails = 0; // assertion failures so far

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			since_act <= 8'hff;
			since_pre <= 8'hff;
			since_ref <= 8'hff;
		end else begin
			since_act <= (cmd_q == ACT) ? 8'd1 : since_act + (since_act != 8'hff); // saturating
			since_pre <= (cmd_q == PRE) ? 8'd1 : since_pre + (since_pre != 8'hff);
			since_ref <= (cmd_q == REF) ? 8'd1 : since_ref + (since_ref != 8'hff);
		end
	end

	a_rcd: assert property (@(posedge sys_clk) disable iff (!arst_n || bypass)
		(cmd_q == RD || cmd_q == WR) |-> since_act > t_rcd)
		else begin
			fails++;
			$error("rd or wr issued too soon after act");
		end
	a_rp: assert property (@(posedge sys_clk) disable iff (!arst_n || bypass)
		(cmd_q == ACT) |-> since_pre > t_rp)
		else begin
			fails++;
			$error("act issued too soon after pre");
		end
	a_rfc: assert property (@(posedge sys_clk) disable iff (!arst_n || bypass)
		(cmd_q == ACT) |-> since_ref > t_rfc)
		else begin
			fails++;
			$error("act issued inside the refresh cycle time");
		end
	a_ack: assert property (@(posedge sys_clk) disable iff (!arst_n)
		fml_ack |=> !fml_ack)
		else begin
			fails++;
			$error("fml_ack held for two cycles");
		end

endmodule

bind ddram_ctrl ddram_props props (
	.sys_clk(sys_clk), .arst_n(arst_n), .bypass(bypass),
	.t_rp(t_rp), .t_rcd(t_rcd), .t_rfc(t_rfc),
	.fml_ack(fml_ack), .cmd_q(cmd_q)
);

/* test/ddram_tb.sv */
// ddram testbench
// runs reset, csr, bypass, traffic and refresh tests on the controller
// against a behavioral sdram model, with lcg stimulus and a watchdog

`timescale 1ns/1ps
`include "ddram_defs.svh"

module ddram_tb;

	import ddram_pkg::*;

	localparam int N_TRAFFIC = 24; // words written then read in test 4
	localparam int N_REFRESH = 32; // words in the long refresh run
	localparam int WORST     = 40; // worst access in cycles, refresh included
	localparam int LIMIT     = (2 * (N_TRAFFIC + N_REFRESH)) * WORST + 3000;
	localparam logic [31:0] TIM_DEF = (780 << 10) | (8 << 6) | (2 << 3) | 2;

	logic                           sys_clk = 1'b0;
	logic                           arst_n = 1'b0;
	logic [`DDRAM_CSR_AW-1:0]       csr_a = '0;
	logic                           csr_we = 1'b0;
	logic [31:0]                    csr_di = '0;
	logic [31:0]                    csr_do;
	logic [`DDRAM_DEPTH-1:0]        fml_adr = '0;
	logic                           fml_stb = 1'b0;
	logic                           fml_we = 1'b0;
	logic                           fml_ack;
	logic [7:0]                     fml_sel = '0;
	logic [63:0]                    fml_di = '0;
	logic [63:0]                    fml_do;
	logic                           sdram_cke;
	logic                           sdram_cs_n;
	logic                           sdram_we_n;
	logic                           sdram_cas_n;
	logic                           sdram_ras_n;
	logic [`DDRAM_ROWDEPTH-1:0]     sdram_adr;
	logic [`DDRAM_BANKDEPTH-1:0]    sdram_ba;
	logic [3:0]                     sdram_dm;
	wire  [31:0]                    sdram_dq;
	logic [31:0]                    seed = 32'h722f5ea9;
	int                             ref_count = 0; // ref commands seen on the pads

	ddram dut (.*);
	ddram_checker chk (.*);

	always #2 sys_clk = ~sys_clk; // 4 ns period

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// behavioral sdram, one open row per bank, byte writes under dm
	logic [31:0]                 sd_mem [logic [27:0]];
	logic [`DDRAM_ROWDEPTH-1:0]  open_row [4];
	logic [3:0]                  row_open = '0;
	logic                        rv [1:`DDRAM_CL+1]; // rd seen j cycles ago
	logic [27:0]                 rkey [1:`DDRAM_CL+1];
	logic                        wv1 = 1'b0; // write beat 0 due
	logic                        wv2 = 1'b0; // write beat 1 due
	logic [27:0]                 wkey1;
	logic [27:0]                 wkey2;
	logic                        drv_oe = 1'b0;
	logic [31:0]                 drv_val;

	assign sdram_dq = drv_oe ? drv_val : 'z;

	initial for (int j = 1; j <= `DDRAM_CL + 1; j++) rv[j] = 1'b0;

	function automatic logic [31:0] sd_read(input logic [27:0] k);
		return sd_mem.exists(k) ? sd_mem[k] : 32'hx;
	endfunction

	task automatic sd_write(input logic [27:0] k);
		logic [31:0] w;
		w = sd_read(k);
		for (int i = 0; i < 4; i++)
			if (!sdram_dm[i]) w[8*i +: 8] = sdram_dq[8*i +: 8];
		sd_mem[k] = w;
	endtask

	always @(posedge sys_clk) begin
		cmd_t        c;
		logic [27:0] k;
		c = cmd_t'({sdram_ras_n, sdram_cas_n, sdram_we_n});
		k = {sdram_ba, open_row[sdram_ba], sdram_adr};
		if (wv1) sd_write(wkey1);
		if (wv2) sd_write(wkey2 + 28'd1);
		drv_oe  <= rv[`DDRAM_CL-1] | rv[`DDRAM_CL]; // beats cl cycles after rd
		drv_val <= rv[`DDRAM_CL-1] ? sd_read(rkey[`DDRAM_CL-1]) : sd_read(rkey[`DDRAM_CL] + 28'd1);
		for (int j = `DDRAM_CL + 1; j > 1; j--) begin
			rv[j]   <= rv[j-1];
			rkey[j] <= rkey[j-1];
		end
		wv2   <= wv1;
		wkey2 <= wkey1;
		rv[1] <= 1'b0;
		wv1   <= 1'b0;
		if (arst_n && !sdram_cs_n) begin
			case (c)
				ACT: begin
					open_row[sdram_ba] = sdram_adr;
					row_open[sdram_ba] = 1'b1;
				end
				PRE: begin
					if (sdram_adr[`DDRAM_A10])
						row_open = '0;
					else
						row_open[sdram_ba] = 1'b0;
				end
				REF: ref_count++;
				RD, WR: begin
					// software may address any bank while it owns the pads
					if (!row_open[sdram_ba] && !chk.byp_q)
						chk.note_failure("read or write issued to a closed bank");
					if (c == RD) begin
						rv[1]   <= 1'b1;
						rkey[1] <= k;
					end else begin
						wv1   <= 1'b1;
						wkey1 <= k;
					end
				end
				default: ;
			endcase
		end
	end

	task automatic csr_write(input logic [`DDRAM_CSR_AW-1:0] a, input logic [31:0] d);
		@(negedge sys_clk);
		csr_a  = a;
		csr_di = d;
		csr_we = 1'b1;
		@(negedge sys_clk); // write edge has passed
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [`DDRAM_CSR_AW-1:0] a, output logic [31:0] d);
		@(negedge sys_clk);
		csr_a = a;
		@(negedge sys_clk);
		d = csr_do;
	endtask

	task automatic fml_access(input logic we, input logic [24:0] a, input logic [7:0] sel,
	                          input logic [63:0] d);
		int n;
		@(negedge sys_clk);
		fml_stb = 1'b1;
		fml_we  = we;
		fml_adr = a;
		fml_sel = sel;
		fml_di  = d;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!fml_ack && n < WORST * 4);
		if (!fml_ack)
			chk.note_failure("fml request was never acknowledged");
		fml_stb = 1'b0;
	endtask

	task automatic run_traffic(input int n);
		logic [24:0] adrs [$];
		logic [24:0] a;
		adrs = {};
		for (int i = 0; i < n; i++) begin
			a = 25'(rand32()) & 25'h1fffff8; // word aligned
			adrs.push_back(a);
			fml_access(1'b1, a, 8'(rand32()), {rand32(), rand32()});
		end
		foreach (adrs[i])
			fml_access(1'b0, adrs[i], 8'h00, 64'h0);
	endtask

	task automatic bypass_cmd(input logic [31:0] d);
		csr_write(14'd1, d);
		chk.check_value("bypass pads", {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n,
			sdram_adr, sdram_ba}, {~d[0], ~d[3], ~d[2], ~d[1], d[16:4], d[18:17]});
		@(negedge sys_clk);
		chk.check_value("bypass nop", {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n},
			4'b1111);
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] t;
		int          c0;
		repeat (16) @(posedge sys_clk);
		@(negedge sys_clk);
		chk.check_value("pads in reset", {sdram_cke, sdram_cs_n, fml_ack}, 3'b010);
		arst_n = 1'b1;
		csr_read(14'd0, d);
		chk.check_value("control reset", d, 32'd3);
		csr_read(14'd2, d);
		chk.check_value("timing reset", d, TIM_DEF);
		chk.check_value("pads after reset", {sdram_cke, sdram_cs_n, fml_ack}, 3'b010);
		chk.test_done("reset state");

		for (int i = 0; i < 8; i++) begin
			t = rand32() & 32'h1fffff;
			csr_write(14'd2, t);
			csr_read(14'd2, d);
			chk.check_value("timing round trip", d, t);
		end
		csr_read({4'h5, 8'h0, 2'd2}, d);
		chk.check_value("unselected read", d, 32'd0);
		csr_write(14'd2, TIM_DEF);
		chk.test_done("csr round trip");

		for (int i = 0; i < 12; i++)
			bypass_cmd(rand32() & 32'h7ffff);
		bypass_cmd(32'h0000_400b); // pre all banks
		bypass_cmd(32'h0000_000d); // refresh
		bypass_cmd(32'h0000_0220 | 32'hf); // load mode register, cl 2
		chk.test_done("bypass commands");

		@(negedge sys_clk);
		fml_stb = 1'b1; // held off while bypass is set
		fml_adr = '0;
		repeat (20) @(negedge sys_clk);
		fml_stb = 1'b0;
		csr_write(14'd0, 32'd4); // release reset and bypass, cke on
		run_traffic(N_TRAFFIC);
		chk.test_done("write read traffic");

		csr_write(14'd2, (40 << 10) | (8 << 6) | (2 << 3) | 2);
		c0 = ref_count;
		t = $time;
		run_traffic(N_REFRESH);
		d = ($time - t) / 4; // elapsed cycles
		if (ref_count - c0 < d / (40 + WORST))
			chk.note_failure("too few refresh commands during traffic");
		chk.test_done("refresh");

		chk.summary(dut.ctrl.props.fails);
		if (chk.errors == 0 && dut.ctrl.props.fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		repeat (LIMIT) @(posedge sys_clk);
		$display("watchdog timeout, the run did not finish in time");
		$display("Test FAILED");
		$finish;
	end

endmodule
